//--- include/fatLogger_macros.svh
// FAT logger constants
`ifndef FATLOGGER_MACROS_SVH
`define FATLOGGER_MACROS_SVH

// ---------------------------------------------------------------------------
// on-disk layout
// ---------------------------------------------------------------------------
`define FAT_SECTOR_BYTES   512
// partition start in the first MBR entry, little endian
`define FAT_PART_LBA_OFS   454
`define FAT_BPB_SPC_OFS    13
`define FAT_BPB_RSVD_OFS   14
`define FAT_BPB_NFATS_OFS  16
`define FAT_BPB_FATSZ_OFS  36
// exclusive bounds of a believable root sector
`define FAT_ROOT_MIN       512
`define FAT_ROOT_MAX       65536
// 8.3 short name, space padded, no dot
`define FAT_LOG_NAME       "SAVEDATADAT"

// serial side and buffering
`define UART_CLK_FREQ      20000000
`define UART_BAUD          921600
`define FIFO_ADDR_BITS     12

`endif

//--- rtl/fatLayoutPkg.sv
// FAT32 layout types
`include "fatLogger_macros.svh"

package fatLayoutPkg;

  // absolute sector number on the card
  typedef logic [31:0] sectorT;

  // byte position inside one sector
  typedef logic [$clog2(`FAT_SECTOR_BYTES)-1:0] byteOfsT;

  // geometry gathered from MBR and BPB
  typedef struct packed {
    sectorT      partStart;
    // first sector of cluster 2, the root directory
    sectorT      rootSector;
    logic [7:0]  sectorsPerCluster;
  } fsGeomT;

endpackage

//--- rtl/loggerCtrlPkg.sv
// Logger control types
`include "fatLogger_macros.svh"

package loggerCtrlPkg;

  // work states, read side first, write side last
  typedef enum logic [3:0] {
    stReset,
    stReadMbr,
    stCheckMbr,
    stReadBpb,
    stCheckBpb,
    stReadDir,
    stCheckDir,
    stWaitData,
    stWriteBlock
  } logStateT;

  // one extra bit so a full FIFO is representable
  typedef logic [`FIFO_ADDR_BITS:0] fifoCountT;

endpackage

//--- rtl/sectorReadIf.sv
// Sector read byte stream
`timescale 1ns/1ps

interface sectorReadIf;
  import fatLayoutPkg::*;

  // one byte per rdValid, bytes 0 to 511 in order
  logic    rdValid;
  byteOfsT rdOfs;
  logic [7:0] rdByte;
  // single cycle after the last byte
  logic    rdDone;

  // card side
  modport source (output rdValid, output rdOfs, output rdByte, output rdDone);

  // parsers and sequencer
  modport sink (input rdValid, input rdOfs, input rdByte, input rdDone);

endinterface

//--- rtl/uartByteRx.sv
// UART 8N1 receiver
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module uartByteRx (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx,
  output logic [7:0] rxByte,
  output logic       rxValid
);

  // bit period in clocks, truncated
  localparam int BitClks  = `UART_CLK_FREQ / `UART_BAUD;
  localparam int HalfClks = BitClks / 2;
  localparam int CntBits  = $clog2(BitClks + 1);

  typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

  rxStateT            rxState;
  logic               rxMeta;
  logic               rxSync;
  logic [CntBits-1:0] bitTimer;
  logic [2:0]         bitIdx;
  logic               bitEnd;
  logic               sampleData;
  logic [7:0]         shiftReg;

  // two flop synchronizer, idles high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  assign bitEnd     = (bitTimer == CntBits'(BitClks - 1));
  assign sampleData = (rxState == rxData) && bitEnd;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxState  <= rxIdle;
      bitTimer <= '0;
      bitIdx   <= '0;
      rxValid  <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      case (rxState)
        rxIdle: begin
          bitTimer <= '0;
          if (!rxSync) begin
            rxState <= rxStart;
          end
        end
        // half a bit to land mid start bit
        rxStart: begin
          if (bitTimer == CntBits'(HalfClks - 1)) begin
            bitTimer <= '0;
            bitIdx   <= '0;
            // glitch shorter than half a bit goes back to idle
            rxState  <= rxSync ? rxIdle : rxData;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        rxData: begin
          if (bitEnd) begin
            bitTimer <= '0;
            bitIdx   <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) begin
              rxState <= rxStop;
            end
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        // mid stop bit, framing check
        rxStop: begin
          if (bitEnd) begin
            rxValid <= rxSync;
            rxState <= rxIdle;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (sampleData) begin
      shiftReg <= {rxSync, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

endmodule

//--- rtl/byteFifo.sv
// Byte FIFO with fill count
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module byteFifo (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     push,
  input  logic [7:0]               pushByte,
  input  logic                     pop,
  output logic [7:0]               headByte,
  output loggerCtrlPkg::fifoCountT count
);

  localparam int Depth = 1 << `FIFO_ADDR_BITS;

  logic [7:0]                mem [Depth];
  logic [`FIFO_ADDR_BITS-1:0] wrPtr;
  logic [`FIFO_ADDR_BITS-1:0] rdPtr;
  logic                      doPush;
  logic                      doPop;

  // full drops the byte, empty ignores the pop
  assign doPush = push && (count != Depth);
  assign doPop  = pop && (count != '0);

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushByte;
    end
  end

  // fall-through head, no pop needed to see it
  assign headByte = mem[rdPtr];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // pointers wrap on their own width
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/bootRecordParser.sv
// MBR and BPB field parser
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module bootRecordParser (
  input  logic                    clk,
  input  logic                    rstn,
  sectorReadIf.sink               rd,
  input  loggerCtrlPkg::logStateT phase,
  output fatLayoutPkg::fsGeomT    geom
);
  import fatLayoutPkg::*;
  import loggerCtrlPkg::*;

  // raw BPB fields
  logic [15:0] rsvdSectors;
  logic [7:0]  numFats;
  sectorT      fatSize;
  logic        mbrByte;
  logic        bpbByte;

  assign mbrByte = rd.rdValid && (phase == stReadMbr);
  assign bpbByte = rd.rdValid && (phase == stReadBpb);

  // ---------------------------------------------------------------------------
  // BPB capture, all fields little endian
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (bpbByte) begin
      case (rd.rdOfs)
        byteOfsT'(`FAT_BPB_RSVD_OFS):      rsvdSectors[7:0]  <= rd.rdByte;
        byteOfsT'(`FAT_BPB_RSVD_OFS + 1):  rsvdSectors[15:8] <= rd.rdByte;
        byteOfsT'(`FAT_BPB_NFATS_OFS):     numFats           <= rd.rdByte;
        byteOfsT'(`FAT_BPB_FATSZ_OFS):     fatSize[7:0]      <= rd.rdByte;
        byteOfsT'(`FAT_BPB_FATSZ_OFS + 1): fatSize[15:8]     <= rd.rdByte;
        byteOfsT'(`FAT_BPB_FATSZ_OFS + 2): fatSize[23:16]    <= rd.rdByte;
        byteOfsT'(`FAT_BPB_FATSZ_OFS + 3): fatSize[31:24]    <= rd.rdByte;
        default: ;
      endcase
    end
  end

  // geometry seen by the sequencer checks
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      geom <= '0;
    end else begin
      // partition start from the first MBR entry
      if (mbrByte) begin
        case (rd.rdOfs)
          byteOfsT'(`FAT_PART_LBA_OFS):     geom.partStart[7:0]   <= rd.rdByte;
          byteOfsT'(`FAT_PART_LBA_OFS + 1): geom.partStart[15:8]  <= rd.rdByte;
          byteOfsT'(`FAT_PART_LBA_OFS + 2): geom.partStart[23:16] <= rd.rdByte;
          byteOfsT'(`FAT_PART_LBA_OFS + 3): geom.partStart[31:24] <= rd.rdByte;
          default: ;
        endcase
      end
      if (bpbByte && rd.rdOfs == byteOfsT'(`FAT_BPB_SPC_OFS)) begin
        geom.sectorsPerCluster <= rd.rdByte;
      end
      // root cluster taken as 2, so root is the first data sector
      if (rd.rdDone && phase == stReadBpb) begin
        geom.rootSector <= geom.partStart + sectorT'(rsvdSectors)
                           + sectorT'(numFats) * fatSize;
      end
    end
  end

endmodule

//--- rtl/dirEntryMatcher.sv
// Directory short name search
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module dirEntryMatcher (
  input  logic                 clk,
  input  logic                 rstn,
  sectorReadIf.sink            rd,
  input  logic                 scan,
  input  fatLayoutPkg::fsGeomT geom,
  output logic                 found,
  output fatLayoutPkg::sectorT fileSector
);
  import fatLayoutPkg::*;

  localparam logic [87:0] LogName = `FAT_LOG_NAME;

  logic [4:0] entOfs;
  logic [7:0] nameByte;
  logic       nameOk;
  logic       entryHit;
  logic       hit;
  sectorT     entCluster;
  sectorT     fileCluster;

  // 32-byte entries, so the low offset bits index the entry
  assign entOfs   = rd.rdOfs[4:0];
  // first character sits in the top byte of the literal
  assign nameByte = (entOfs < 5'd11) ? LogName[8 * (10 - entOfs) +: 8] : 8'h00;
  // last byte of an entry whose whole name compared equal
  assign entryHit = scan && rd.rdValid && (entOfs == 5'd31) && nameOk;

  // start cluster, high word at 20 and low word at 26
  always_ff @(posedge clk) begin
    if (scan && rd.rdValid) begin
      case (entOfs)
        5'd20:   entCluster[23:16] <= rd.rdByte;
        5'd21:   entCluster[31:24] <= rd.rdByte;
        5'd26:   entCluster[7:0]   <= rd.rdByte;
        5'd27:   entCluster[15:8]  <= rd.rdByte;
        default: ;
      endcase
    end
    if (entryHit) begin
      fileCluster <= entCluster;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      nameOk     <= 1'b0;
      hit        <= 1'b0;
      found      <= 1'b0;
      fileSector <= '0;
    end else if (!scan) begin
      // found holds until the next sector scan
      hit <= 1'b0;
    end else begin
      if (rd.rdValid && entOfs == 5'd0) begin
        nameOk <= (rd.rdByte == nameByte);
      end else if (rd.rdValid && entOfs < 5'd11) begin
        nameOk <= nameOk && (rd.rdByte == nameByte);
      end
      if (entryHit) begin
        hit <= 1'b1;
      end
      // verdict for the whole sector
      found <= rd.rdDone && hit;
      if (rd.rdDone) begin
        fileSector <= geom.rootSector
                      + (fileCluster - 32'd2) * sectorT'(geom.sectorsPerCluster);
      end
    end
  end

endmodule

//--- rtl/logSequencer.sv
// Logger work-state sequencer
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module logSequencer (
  input  logic                     clk,
  input  logic                     rstn,
  sectorReadIf.sink                rd,
  input  fatLayoutPkg::fsGeomT     geom,
  input  logic                     found,
  input  fatLayoutPkg::sectorT     fileSector,
  input  loggerCtrlPkg::fifoCountT fifoCount,
  input  logic                     blkWriteReq,
  input  logic                     blkWriteDone,
  output logic                     blkReadStart,
  output logic                     blkWriteStart,
  output fatLayoutPkg::sectorT     blkSector,
  output logic                     scan,
  output loggerCtrlPkg::logStateT  state
);
  import fatLayoutPkg::*;
  import loggerCtrlPkg::*;

  sectorT     readSector;
  sectorT     blockCount;
  logic [9:0] reqCount;
  logic       blockReady;
  logic       rootOk;
  logic       writing;

  // ---------------------------------------------------------------------------
  // decodes
  // ---------------------------------------------------------------------------
  assign blockReady = fifoCount >= fifoCountT'(`FAT_SECTOR_BYTES);
  assign rootOk     = (geom.rootSector > `FAT_ROOT_MIN)
                      && (geom.rootSector < `FAT_ROOT_MAX);
  assign writing    = (state == stWaitData) || (state == stWriteBlock);
  assign scan       = (state == stReadDir);

  // write start only ever comes from stWaitData, one cycle
  assign blkWriteStart = (state == stWaitData) && blockReady;
  // next file sector while writing, else the read target
  assign blkSector     = writing ? fileSector + blockCount : readSector;

  // ---------------------------------------------------------------------------
  // work states
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= stReset;
      blkReadStart <= 1'b0;
      readSector   <= '0;
      blockCount   <= '0;
      reqCount     <= '0;
    end else begin
      blkReadStart <= 1'b0;
      case (state)
        stReset: begin
          readSector   <= '0;
          blkReadStart <= 1'b1;
          state        <= stReadMbr;
        end
        stReadMbr: begin
          if (rd.rdDone) begin
            state <= stCheckMbr;
          end
        end
        // empty partition entry means read sector 0 once more
        stCheckMbr: begin
          blkReadStart <= 1'b1;
          if (geom.partStart == '0) begin
            readSector <= '0;
            state      <= stReadMbr;
          end else begin
            readSector <= geom.partStart;
            state      <= stReadBpb;
          end
        end
        stReadBpb: begin
          if (rd.rdDone) begin
            state <= stCheckBpb;
          end
        end
        stCheckBpb: begin
          blkReadStart <= 1'b1;
          if (rootOk) begin
            readSector <= geom.rootSector;
            state      <= stReadDir;
          end else begin
            readSector <= geom.partStart;
            state      <= stReadBpb;
          end
        end
        stReadDir: begin
          if (rd.rdDone) begin
            state <= stCheckDir;
          end
        end
        // miss steps on to the next directory sector
        stCheckDir: begin
          if (found) begin
            blockCount <= '0;
            state      <= stWaitData;
          end else begin
            readSector   <= readSector + 1'b1;
            blkReadStart <= 1'b1;
            state        <= stReadDir;
          end
        end
        stWaitData: begin
          reqCount <= '0;
          if (blockReady) begin
            state <= stWriteBlock;
          end
        end
        stWriteBlock: begin
          if (blkWriteReq) begin
            reqCount <= reqCount + 1'b1;
          end
          // a short block leaves the sector index where it was
          if (blkWriteDone) begin
            if (reqCount == 10'(`FAT_SECTOR_BYTES)) begin
              blockCount <= blockCount + 1'b1;
            end
            state <= stWaitData;
          end
        end
        default: state <= stReset;
      endcase
    end
  end

endmodule

//--- rtl/fatLoggerTop.sv
// FAT32 logger top level
`timescale 1ns/1ps

module fatLoggerTop (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    rx,
  output logic                    blkReadStart,
  output logic                    blkWriteStart,
  output fatLayoutPkg::sectorT    blkSector,
  output logic [7:0]              blkWriteByte,
  input  logic                    blkWriteReq,
  input  logic                    blkWriteDone,
  input  logic                    rdValid,
  input  fatLayoutPkg::byteOfsT   rdOfs,
  input  logic [7:0]              rdByte,
  input  logic                    rdDone,
  output loggerCtrlPkg::logStateT state
);
  import fatLayoutPkg::*;
  import loggerCtrlPkg::*;

  logic      [7:0] rxByte;
  logic      rxValid;
  fifoCountT fifoCount;
  fsGeomT    geom;
  logic      scan;
  logic      found;
  sectorT    fileSector;

  // ---------------------------------------------------------------------------
  // card read stream onto the shared bus
  // ---------------------------------------------------------------------------
  sectorReadIf rdBus ();

  assign rdBus.rdValid = rdValid;
  assign rdBus.rdOfs   = rdOfs;
  assign rdBus.rdByte  = rdByte;
  assign rdBus.rdDone  = rdDone;

  uartByteRx i_uartByteRx (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rxByte  (rxByte),
    .rxValid (rxValid)
  );

  // card pulls bytes straight off the FIFO head
  byteFifo i_byteFifo (
    .clk      (clk),
    .rstn     (rstn),
    .push     (rxValid),
    .pushByte (rxByte),
    .pop      (blkWriteReq),
    .headByte (blkWriteByte),
    .count    (fifoCount)
  );

  bootRecordParser i_bootRecordParser (
    .clk   (clk),
    .rstn  (rstn),
    .rd    (rdBus.sink),
    .phase (state),
    .geom  (geom)
  );

  dirEntryMatcher i_dirEntryMatcher (
    .clk        (clk),
    .rstn       (rstn),
    .rd         (rdBus.sink),
    .scan       (scan),
    .geom       (geom),
    .found      (found),
    .fileSector (fileSector)
  );

  logSequencer i_logSequencer (
    .clk           (clk),
    .rstn          (rstn),
    .rd            (rdBus.sink),
    .geom          (geom),
    .found         (found),
    .fileSector    (fileSector),
    .fifoCount     (fifoCount),
    .blkWriteReq   (blkWriteReq),
    .blkWriteDone  (blkWriteDone),
    .blkReadStart  (blkReadStart),
    .blkWriteStart (blkWriteStart),
    .blkSector     (blkSector),
    .scan          (scan),
    .state         (state)
  );

endmodule

//--- tests/fatLogger_properties.sv
// Block port assertions
`timescale 1ns/1ps

module blockPortProps (
  input logic                    clk,
  input logic                    rstn,
  input logic                    blkReadStart,
  input logic                    blkWriteStart,
  input loggerCtrlPkg::logStateT state
);
  import loggerCtrlPkg::*;

  // number of failed assertions so far
  int failCount = 0;

  // read start is a single cycle pulse
  readPulse: assert property (@(posedge clk) disable iff (!rstn)
    blkReadStart |=> !blkReadStart)
    else begin
      $error("blkReadStart stayed high for more than one cycle");
      failCount++;
    end

  // write start is a single cycle pulse
  writePulse: assert property (@(posedge clk) disable iff (!rstn)
    blkWriteStart |=> !blkWriteStart)
    else begin
      $error("blkWriteStart stayed high for more than one cycle");
      failCount++;
    end

  // card sees one request kind at a time
  noOverlap: assert property (@(posedge clk) disable iff (!rstn)
    !(blkReadStart && blkWriteStart))
    else begin
      $error("blkReadStart and blkWriteStart high together");
      failCount++;
    end

  // writes only leave the idle write state
  writeFromWait: assert property (@(posedge clk) disable iff (!rstn)
    blkWriteStart |-> state == stWaitData)
    else begin
      $error("blkWriteStart outside stWaitData");
      failCount++;
    end

endmodule

bind fatLoggerTop blockPortProps i_blockPortProps (
  .clk           (clk),
  .rstn          (rstn),
  .blkReadStart  (blkReadStart),
  .blkWriteStart (blkWriteStart),
  .state         (state)
);

//--- tests/fatLoggerTb.sv
// FAT logger testbench
`timescale 1ns/1ps
`include "fatLogger_macros.svh"

module fatLoggerTb;
  import fatLayoutPkg::*;
  import loggerCtrlPkg::*;

  localparam int ClkPeriod  = 100;
  // bit period in DUT clocks, same rounding as the receiver
  localparam int BitClks    = `UART_CLK_FREQ / `UART_BAUD;
  localparam int SecBytes   = `FAT_SECTOR_BYTES;
  localparam int NumSlots   = 4;
  localparam int TotalBytes = 1024;

  // watchdog budget, summed test lengths
  localparam int ReadCycles  = 8 * (8 + SecBytes + 8);
  localparam int UartCycles  = TotalBytes * 10 * BitClks;
  localparam int WriteCycles = 2 * SecBytes * 4 + 64;
  localparam int RunCycles   = 5 + ReadCycles + UartCycles + WriteCycles;

  // card image geometry
  localparam logic [31:0] PartStart   = 32'h0000_0800;
  localparam logic [31:0] RsvdSectors = 32;
  localparam logic [31:0] NumFats     = 2;
  localparam logic [31:0] BadFatSize  = 40000;
  localparam logic [31:0] GoodFatSize = 1000;
  localparam logic [31:0] SecPerClus  = 8;
  localparam logic [31:0] FileCluster = 32'h0001_0003;
  // root is the first data sector, cluster 2
  localparam logic [31:0] RootSector  = PartStart + RsvdSectors + NumFats * GoodFatSize;
  localparam logic [31:0] FileSector  = RootSector + (FileCluster - 2) * SecPerClus;
  localparam string       LogName     = `FAT_LOG_NAME;

  logic       clk = 1'b0;
  logic       rstn;
  logic       rx;
  logic       blkReadStart;
  logic       blkWriteStart;
  sectorT     blkSector;
  logic [7:0] blkWriteByte;
  logic       blkWriteReq;
  logic       blkWriteDone;
  logic       rdValid;
  byteOfsT    rdOfs;
  logic [7:0] rdByte;
  logic       rdDone;
  logStateT   state;

  int          seed = 32'he96c;
  int          bytesStarted = 0;
  int          writeStarts = 0;
  logic [7:0]  sentBytes [TotalBytes];
  // card model, a few sectors by number
  logic [31:0] slotSector [NumSlots];
  logic [7:0]  diskData [NumSlots][SecBytes];

  always #(ClkPeriod / 2) clk = ~clk;

  fatLoggerTop i_fatLoggerTop (
    .clk           (clk),
    .rstn          (rstn),
    .rx            (rx),
    .blkReadStart  (blkReadStart),
    .blkWriteStart (blkWriteStart),
    .blkSector     (blkSector),
    .blkWriteByte  (blkWriteByte),
    .blkWriteReq   (blkWriteReq),
    .blkWriteDone  (blkWriteDone),
    .rdValid       (rdValid),
    .rdOfs         (rdOfs),
    .rdByte        (rdByte),
    .rdDone        (rdDone),
    .state         (state)
  );

  // count write starts, nonblocking so same-edge readers see the old value
  always @(negedge clk) begin
    if (rstn && blkWriteStart) begin
      writeStarts <= writeStarts + 1;
    end
  end

  // -------------------------------------------------------------------------
  // reporting
  // -------------------------------------------------------------------------
  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  initial begin
    #(2 * RunCycles * ClkPeriod);
    stopOnError("watchdog timeout, the tests did not finish in time");
  end

  // -------------------------------------------------------------------------
  // card model
  // -------------------------------------------------------------------------
  function automatic int slotOf(input logic [31:0] sec);
    int idx;
    idx = -1;
    for (int s = 0; s < NumSlots; s++) begin
      if (slotSector[s] == sec) begin
        idx = s;
      end
    end
    return idx;
  endfunction

  // MBR, BPB, two directory sectors
  task automatic clearDisk;
    slotSector[0] = 32'h0;
    slotSector[1] = PartStart;
    slotSector[2] = RootSector;
    slotSector[3] = RootSector + 1;
    for (int s = 0; s < NumSlots; s++) begin
      for (int i = 0; i < SecBytes; i++) begin
        diskData[s][i] = 8'h00;
      end
    end
  endtask

  // little endian field
  task automatic putLe(input int slot, input int ofs, input logic [31:0] value,
                       input int len);
    for (int i = 0; i < len; i++) begin
      diskData[slot][ofs + i] = value[8 * i +: 8];
    end
  endtask

  task automatic putBpb(input logic [31:0] fatSize);
    putLe(1, `FAT_BPB_SPC_OFS, SecPerClus, 1);
    putLe(1, `FAT_BPB_RSVD_OFS, RsvdSectors, 2);
    putLe(1, `FAT_BPB_NFATS_OFS, NumFats, 1);
    putLe(1, `FAT_BPB_FATSZ_OFS, fatSize, 4);
  endtask

  task automatic putDirEntry(input int slot, input int entry, input string name,
                             input logic [31:0] cluster);
    int base;
    base = 32 * entry;
    for (int i = 0; i < 11; i++) begin
      diskData[slot][base + i] = name[i];
    end
    // high cluster word at 20, low at 26
    putLe(slot, base + 20, cluster[31:16], 2);
    putLe(slot, base + 26, cluster[15:0], 2);
  endtask

  // random latency, then bytes 0 to 511 and a done pulse
  task automatic serveRead(input logic [31:0] sec);
    int slot;
    int delay;
    slot  = slotOf(sec);
    delay = 1 + ({$random(seed)} % 8);
    repeat (delay) @(negedge clk);
    for (int i = 0; i < SecBytes; i++) begin
      rdValid = 1'b1;
      rdOfs   = byteOfsT'(i);
      rdByte  = (slot < 0) ? 8'h00 : diskData[slot][i];
      @(negedge clk);
    end
    rdValid = 1'b0;
    rdDone  = 1'b1;
    @(negedge clk);
    rdDone  = 1'b0;
  endtask

  task automatic waitReadStart(output logic [31:0] sec);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 100) begin
        stopOnError("no sector read was started within 100 cycles");
      end
    end while (!blkReadStart);
    sec = blkSector;
  endtask

  task automatic waitForState(input logStateT target, input int limit);
    int waited;
    waited = 0;
    while (state != target) begin
      @(negedge clk);
      waited++;
      if (waited > limit) begin
        stopOnError($sformatf("state never reached %s", target.name()));
      end
    end
  endtask

  // takes one block with random request gaps, checks every byte
  task automatic serveWrite(input int blockIdx);
    int waited;
    int gap;
    int base;
    base   = blockIdx * SecBytes;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 2 * UartCycles) begin
        stopOnError("no block write was started");
      end
    end while (!blkWriteStart);
    checkValue("blkSector", blkSector, FileSector + blockIdx);
    if (bytesStarted < base + SecBytes) begin
      stopOnError("block write started before a full sector of bytes was sent");
    end
    // first request one cycle after the start
    @(negedge clk);
    for (int n = 0; n < SecBytes; n++) begin
      gap = {$random(seed)} % 4;
      blkWriteReq = 1'b0;
      repeat (gap) @(negedge clk);
      blkWriteReq = 1'b1;
      checkValue("blkWriteByte", 32'(blkWriteByte), 32'(sentBytes[base + n]));
      @(negedge clk);
    end
    blkWriteReq = 1'b0;
    checkValue("blkSector", blkSector, FileSector + blockIdx);
    blkWriteDone = 1'b1;
    @(negedge clk);
    blkWriteDone = 1'b0;
  endtask

  // -------------------------------------------------------------------------
  // UART side
  // -------------------------------------------------------------------------
  task automatic sendByte(input logic [7:0] value);
    rx = 1'b0;
    bytesStarted++;
    repeat (BitClks) @(negedge clk);
    // lsb first
    for (int i = 0; i < 8; i++) begin
      rx = value[i];
      repeat (BitClks) @(negedge clk);
    end
    rx = 1'b1;
    repeat (BitClks) @(negedge clk);
  endtask

  task automatic sendRange(input int first, input int count);
    for (int k = 0; k < count; k++) begin
      sendByte(sentBytes[first + k]);
    end
  endtask

  // -------------------------------------------------------------------------
  // directed tests
  // -------------------------------------------------------------------------
  task automatic resetTest;
    logic [31:0] sec;
    checkValue("state", 32'(state), 32'(stReset));
    checkValue("blkReadStart", 32'(blkReadStart), 32'h0);
    checkValue("blkWriteStart", 32'(blkWriteStart), 32'h0);
    waitReadStart(sec);
    checkValue("blkSector", sec, 32'h0);
  endtask

  task automatic mbrRetryTest;
    logic [31:0] sec;
    // partition entry still empty
    serveRead(32'h0);
    waitReadStart(sec);
    checkValue("blkSector", sec, 32'h0);
    putLe(0, `FAT_PART_LBA_OFS, PartStart, 4);
    serveRead(sec);
    waitReadStart(sec);
    checkValue("blkSector", sec, PartStart);
  endtask

  task automatic bpbRetryTest;
    logic [31:0] sec;
    // root lands past the plausible range
    putBpb(BadFatSize);
    serveRead(PartStart);
    waitReadStart(sec);
    checkValue("blkSector", sec, PartStart);
    putBpb(GoodFatSize);
    serveRead(sec);
    waitReadStart(sec);
    checkValue("blkSector", sec, RootSector);
  endtask

  task automatic dirSearchTest;
    logic [31:0] sec;
    // near miss in the root sector, real name one sector on
    putDirEntry(2, 0, "SAVEDATATXT", 32'h9);
    putDirEntry(3, 5, LogName, FileCluster);
    serveRead(RootSector);
    waitReadStart(sec);
    checkValue("blkSector", sec, RootSector + 1);
    serveRead(sec);
    waitForState(stWaitData, 100);
  endtask

  task automatic firstBlockTest;
    fork
      sendRange(0, 600);
      serveWrite(0);
    join
    repeat (2 * BitClks) @(negedge clk);
    // 88 bytes left over, not enough for another block
    checkValue("writeStarts", writeStarts, 1);
    checkValue("state", 32'(state), 32'(stWaitData));
  endtask

  task automatic secondBlockTest;
    fork
      sendRange(600, TotalBytes - 600);
      serveWrite(1);
    join
    repeat (2 * BitClks) @(negedge clk);
    checkValue("writeStarts", writeStarts, 2);
    checkValue("state", 32'(state), 32'(stWaitData));
  endtask

  initial begin
    rstn         = 1'b0;
    rx           = 1'b1;
    blkWriteReq  = 1'b0;
    blkWriteDone = 1'b0;
    rdValid      = 1'b0;
    rdOfs        = '0;
    rdByte       = 8'h00;
    rdDone       = 1'b0;
    for (int i = 0; i < TotalBytes; i++) begin
      sentBytes[i] = 8'($random(seed));
    end
    clearDisk();
    repeat (5) @(negedge clk);
    rstn = 1'b1;
    resetTest();
    mbrRetryTest();
    bpbRetryTest();
    dirSearchTest();
    firstBlockTest();
    secondBlockTest();
    repeat (4) @(negedge clk);
    if (i_fatLoggerTop.i_blockPortProps.failCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stopOnError("assertions on the block port failed during the run");
    end
  end

endmodule

//--- compile.f
+incdir+include
rtl/fatLayoutPkg.sv
rtl/loggerCtrlPkg.sv
rtl/sectorReadIf.sv
rtl/uartByteRx.sv
rtl/byteFifo.sv
rtl/bootRecordParser.sv
rtl/dirEntryMatcher.sv
rtl/logSequencer.sv
rtl/fatLoggerTop.sv
tests/fatLogger_properties.sv
tests/fatLoggerTb.sv
